// File: Makefile
VERILATOR ?= verilator
TOP       ?= backend_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

// File: logic/backend.sv
`timescale 1ns/1ps
`default_nettype none

module backend (
	input  logic clk,
	input  logic rst_n_i,

	input  backend_pkg::inst_word_t [backend_pkg::ISSUE_WIDTH-1:0] inst_i, // slot 0 older
	input  logic [backend_pkg::ISSUE_WIDTH-1:0] inst_valid_i,
	output logic [1:0]                          issue_num_o, // 0, 1, 2
	output logic                                backend_stall_o,

	output logic               bus_req_o,
	output logic               bus_we_o,
	output backend_pkg::word_t bus_addr_o,
	output backend_pkg::word_t bus_wdata_o,
	input  logic               bus_ack_i, // one cycle completion
	input  backend_pkg::word_t bus_rdata_i,

	output logic [backend_pkg::ISSUE_WIDTH-1:0]                   commit_we_o,
	output backend_pkg::reg_addr_t [backend_pkg::ISSUE_WIDTH-1:0] commit_addr_o,
	output backend_pkg::word_t     [backend_pkg::ISSUE_WIDTH-1:0] commit_data_o
);
	import backend_pkg::*;

	logic freeze;

	logic [ISSUE_WIDTH-1:0] issue; // per pipe
	logic                   revert;

	reg_addr_t [2*ISSUE_WIDTH-1:0] rs_addr;
	word_t     [2*ISSUE_WIDTH-1:0] rs_data;
	fwd_src_t  [2*ISSUE_WIDTH-1:0] fwd_src;

	word_t     [ISSUE_WIDTH-1:0] m1_data, m2_data;
	reg_addr_t [ISSUE_WIDTH-1:0] ex_rd, m1_rd;
	logic      [ISSUE_WIDTH-1:0] ex_revert, m1_revert, m2_revert;
	logic                        p0_ex_load;

	logic      [ISSUE_WIDTH-1:0] wb_en;   // pipe order
	reg_addr_t [ISSUE_WIDTH-1:0] wb_addr;
	word_t     [ISSUE_WIDTH-1:0] wb_data;
	logic      [ISSUE_WIDTH-1:0] w_en;    // age order, port 1 younger
	reg_addr_t [ISSUE_WIDTH-1:0] w_addr;
	word_t     [ISSUE_WIDTH-1:0] w_data;
	logic                        wb_swap;

	// memory wait stalls the whole backend
	assign freeze          = bus_req_o && !bus_ack_i;
	assign backend_stall_o = freeze;

	issue_ctrl issue_ctrl_module (
		.inst_i       (inst_i),
		.inst_valid_i (inst_valid_i),
		.freeze_i     (freeze),
		.p0_ex_load_i (p0_ex_load),
		.p0_ex_rd_i   (ex_rd[0]),
		.p1_ex_rd_i   (ex_rd[1]),
		.p0_m1_rd_i   (m1_rd[0]),
		.p1_m1_rd_i   (m1_rd[1]),
		.ex_revert_i  (|ex_revert), // both pipes carry the pair's bit
		.m1_revert_i  (|m1_revert),
		.issue_o      (issue),
		.revert_o     (revert),
		.rs_addr_o    (rs_addr),
		.fwd_src_o    (fwd_src)
	);

	// issue is in order so the pattern is 00, 01 or 11
	assign issue_num_o = {issue[1], issue[0] & ~issue[1]};

	reg_file reg_file_module (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.w_addr_i (w_addr),
		.w_data_i (w_data),
		.w_en_i   (w_en),
		.r_addr_i (rs_addr),
		.r_data_o (rs_data)
	);

	backend_pipeline #(
		.MAIN_PIPE (1'b1)
	) pipeline_0 (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.freeze_i    (freeze),
		.issue_i     (issue[0]),
		.revert_i    (revert),
		.inst_i      (inst_i[revert]), // slot 1 when reverted
		.rs_data_i   (rs_data[1:0]),
		.fwd_src_i   (fwd_src[1:0]),
		.fwd_m1_i    (m1_data),
		.fwd_m2_i    (m2_data),
		.m1_data_o   (m1_data[0]),
		.m2_data_o   (m2_data[0]),
		.ex_rd_o     (ex_rd[0]),
		.ex_load_o   (p0_ex_load),
		.m1_rd_o     (m1_rd[0]),
		.ex_revert_o (ex_revert[0]),
		.m1_revert_o (m1_revert[0]),
		.wb_en_o     (wb_en[0]),
		.wb_addr_o   (wb_addr[0]),
		.wb_data_o   (wb_data[0]),
		.m2_revert_o (m2_revert[0]),
		.bus_req_o   (bus_req_o),
		.bus_we_o    (bus_we_o),
		.bus_addr_o  (bus_addr_o),
		.bus_wdata_o (bus_wdata_o),
		.bus_ack_i   (bus_ack_i),
		.bus_rdata_i (bus_rdata_i)
	);

	backend_pipeline #(
		.MAIN_PIPE (1'b0)
	) pipeline_1 (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.freeze_i    (freeze),
		.issue_i     (issue[1]),
		.revert_i    (revert),
		.inst_i      (inst_i[!revert]),
		.rs_data_i   (rs_data[3:2]),
		.fwd_src_i   (fwd_src[3:2]),
		.fwd_m1_i    (m1_data),
		.fwd_m2_i    (m2_data),
		.m1_data_o   (m1_data[1]),
		.m2_data_o   (m2_data[1]),
		.ex_rd_o     (ex_rd[1]),
		.ex_load_o   (),               // loads stay in pipe 0
		.m1_rd_o     (m1_rd[1]),
		.ex_revert_o (ex_revert[1]),
		.m1_revert_o (m1_revert[1]),
		.wb_en_o     (wb_en[1]),
		.wb_addr_o   (wb_addr[1]),
		.wb_data_o   (wb_data[1]),
		.m2_revert_o (m2_revert[1]),
		.bus_req_o   (),
		.bus_we_o    (),
		.bus_addr_o  (),
		.bus_wdata_o (),
		.bus_ack_i   (1'b0),
		.bus_rdata_i ('0)
	);

	// reverted pair has its older op in pipe 1
	assign wb_swap = |m2_revert;

	always_comb begin
		for (int i = 0; i < ISSUE_WIDTH; i++) begin
			w_en[i]   = wb_en[i ^ int'(wb_swap)];
			w_addr[i] = wb_addr[i ^ int'(wb_swap)];
			w_data[i] = wb_data[i ^ int'(wb_swap)];
		end
	end

	// trace mirrors the write ports, already freeze gated
	assign commit_we_o   = w_en;
	assign commit_addr_o = w_addr;
	assign commit_data_o = w_data;

endmodule

`default_nettype wire

// File: logic/backend_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module backend_pipeline #(
	parameter bit MAIN_PIPE = 1'b1 // only the main pipe owns the bus
) (
	input  logic clk,
	input  logic rst_n_i,
	input  logic freeze_i, // holds every stage

	input  logic                                   issue_i,
	input  logic                                   revert_i,
	input  backend_pkg::inst_word_t                inst_i,
	input  backend_pkg::word_t     [1:0]           rs_data_i,
	input  backend_pkg::fwd_src_t  [1:0]           fwd_src_i,

	// forwarding network, index is pipe
	input  backend_pkg::word_t [1:0] fwd_m1_i,
	input  backend_pkg::word_t [1:0] fwd_m2_i,
	output backend_pkg::word_t       m1_data_o,
	output backend_pkg::word_t       m2_data_o,

	// hazard info for issue
	output backend_pkg::reg_addr_t ex_rd_o,
	output logic                   ex_load_o,
	output backend_pkg::reg_addr_t m1_rd_o,
	output logic                   ex_revert_o,
	output logic                   m1_revert_o,

	output logic                   wb_en_o,
	output backend_pkg::reg_addr_t wb_addr_o,
	output backend_pkg::word_t     wb_data_o,
	output logic                   m2_revert_o,

	output logic               bus_req_o,
	output logic               bus_we_o,
	output backend_pkg::word_t bus_addr_o,
	output backend_pkg::word_t bus_wdata_o,
	input  logic               bus_ack_i,
	input  backend_pkg::word_t bus_rdata_i
);
	import backend_pkg::*;

	logic ex_valid, m1_valid, m2_valid;

	op_t            ex_op, m1_op;
	reg_addr_t      ex_rd, m1_rd, m2_rd; // zero for non-writing ops
	word_t          ex_imm;
	word_t          ex_a, ex_b;          // values read at issue
	fwd_src_t [1:0] ex_fwd;
	logic           ex_revert, m1_revert, m2_revert;

	word_t opnd_a, opnd_b, ex_result;
	word_t m1_result, m1_wdata;
	word_t m2_result;

	function automatic word_t fwd_mux(input fwd_src_t sel, input word_t raw,
		input word_t [1:0] m1, input word_t [1:0] m2);
		case (sel)
			FWD_P0_M1: return m1[0];
			FWD_P1_M1: return m1[1];
			FWD_P0_M2: return m2[0];
			FWD_P1_M2: return m2[1];
			default:   return raw;
		endcase
	endfunction

	// valid bits
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			ex_valid <= 1'b0;
			m1_valid <= 1'b0;
			m2_valid <= 1'b0;
		end else if (!freeze_i) begin
			ex_valid <= issue_i;
			m1_valid <= ex_valid;
			m2_valid <= m1_valid;
		end
	end

	// payload, masked by valid downstream
	always_ff @(posedge clk) begin
		if (!freeze_i) begin
			ex_op     <= inst_op(inst_i);
			ex_rd     <= writes_rd(inst_op(inst_i)) ? inst_rd(inst_i) : '0;
			ex_imm    <= imm_ext(inst_i);
			ex_a      <= rs_data_i[0];
			ex_b      <= rs_data_i[1];
			ex_fwd    <= fwd_src_i;
			ex_revert <= revert_i;

			m1_op     <= ex_op;
			m1_rd     <= ex_rd;
			m1_result <= ex_result;
			m1_wdata  <= opnd_b; // store data
			m1_revert <= ex_revert;

			m2_rd     <= m1_rd;
			m2_result <= (m1_op == OP_LW && bus_ack_i) ? bus_rdata_i : m1_result;
			m2_revert <= m1_revert;
		end
	end

	always_comb begin
		opnd_a = fwd_mux(ex_fwd[0], ex_a, fwd_m1_i, fwd_m2_i);
		opnd_b = fwd_mux(ex_fwd[1], ex_b, fwd_m1_i, fwd_m2_i);
		case (ex_op)
			OP_ADD:               ex_result = opnd_a + opnd_b;
			OP_SUB:               ex_result = opnd_a - opnd_b;
			OP_AND:               ex_result = opnd_a & opnd_b;
			OP_OR:                ex_result = opnd_a | opnd_b;
			OP_XOR:               ex_result = opnd_a ^ opnd_b;
			OP_ADDI, OP_LW, OP_SW: ex_result = opnd_a + ex_imm; // also mem address
			default:              ex_result = '0;
		endcase
	end

	assign ex_rd_o     = ex_valid ? ex_rd : '0;
	assign ex_load_o   = ex_valid && ex_op == OP_LW;
	assign m1_rd_o     = m1_valid ? m1_rd : '0;
	assign ex_revert_o = ex_valid && ex_revert;
	assign m1_revert_o = m1_valid && m1_revert;
	assign m2_revert_o = m2_valid && m2_revert;

	assign m1_data_o = m1_result; // never a load, issue blocks that
	assign m2_data_o = m2_result;

	// retire at the edge leaving m2
	assign wb_en_o   = m2_valid && m2_rd != '0 && !freeze_i;
	assign wb_addr_o = m2_rd;
	assign wb_data_o = m2_result;

	if (MAIN_PIPE) begin : g_main
		assign bus_req_o   = m1_valid && is_mem(m1_op); // level until ack
		assign bus_we_o    = m1_valid && m1_op == OP_SW;
		assign bus_addr_o  = m1_result;
		assign bus_wdata_o = m1_wdata;
	end else begin : g_sec
		assign bus_req_o   = 1'b0;
		assign bus_we_o    = 1'b0;
		assign bus_addr_o  = '0;
		assign bus_wdata_o = '0;

		// steering must keep mem ops in pipe 0
		a_no_mem: assert property (@(posedge clk) disable iff (!rst_n_i)
			!(ex_valid && is_mem(ex_op)))
			else $error("backend_pipeline: memory op in secondary pipe");
	end

endmodule

`default_nettype wire

// File: logic/backend_pkg.sv
`default_nettype none

package backend_pkg;

	typedef logic [31:0] word_t;      // reg values, alu results, bus data and addr
	typedef logic [31:0] inst_word_t; // raw instruction from frontend
	typedef logic [4:0]  reg_addr_t;
	typedef logic [3:0]  op_t;
	typedef logic [12:0] imm_t;       // signed
	typedef logic [2:0]  fwd_src_t;   // operand source picked at ex

	localparam int NUM_REGS    = 32;
	localparam int ISSUE_WIDTH = 2;

	// field positions, imm sits at bit 0
	localparam int OP_LSB  = 28;
	localparam int RD_LSB  = 23;
	localparam int RS1_LSB = 18;
	localparam int RS2_LSB = 13;

	localparam op_t OP_NOP  = 4'h0;
	localparam op_t OP_ADD  = 4'h1;
	localparam op_t OP_SUB  = 4'h2;
	localparam op_t OP_AND  = 4'h3;
	localparam op_t OP_OR   = 4'h4;
	localparam op_t OP_XOR  = 4'h5;
	localparam op_t OP_ADDI = 4'h6;
	localparam op_t OP_LW   = 4'h7;
	localparam op_t OP_SW   = 4'h8;

	localparam fwd_src_t FWD_NONE  = 3'd0; // value read at issue
	localparam fwd_src_t FWD_P0_M1 = 3'd1;
	localparam fwd_src_t FWD_P1_M1 = 3'd2;
	localparam fwd_src_t FWD_P0_M2 = 3'd3;
	localparam fwd_src_t FWD_P1_M2 = 3'd4;

	function automatic op_t inst_op(input inst_word_t inst);
		return inst[OP_LSB +: $bits(op_t)];
	endfunction

	function automatic reg_addr_t inst_rd(input inst_word_t inst);
		return inst[RD_LSB +: $bits(reg_addr_t)];
	endfunction

	function automatic reg_addr_t inst_rs1(input inst_word_t inst);
		return inst[RS1_LSB +: $bits(reg_addr_t)];
	endfunction

	function automatic reg_addr_t inst_rs2(input inst_word_t inst);
		return inst[RS2_LSB +: $bits(reg_addr_t)];
	endfunction

	// sign extended imm
	function automatic word_t imm_ext(input inst_word_t inst);
		imm_t imm;
		imm = inst[$bits(imm_t)-1:0];
		return {{($bits(word_t) - $bits(imm_t)){imm[$bits(imm_t)-1]}}, imm};
	endfunction

	function automatic logic is_alu_rr(input op_t op);
		return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
	endfunction

	function automatic logic is_mem(input op_t op);
		return op inside {OP_LW, OP_SW};
	endfunction

	function automatic logic writes_rd(input op_t op);
		return is_alu_rr(op) || op == OP_ADDI || op == OP_LW;
	endfunction

	function automatic logic uses_rs1(input op_t op);
		return is_alu_rr(op) || op inside {OP_ADDI, OP_LW, OP_SW};
	endfunction

	function automatic logic uses_rs2(input op_t op);
		return is_alu_rr(op) || op == OP_SW; // sw data comes from rs2
	endfunction

endpackage

`default_nettype wire

// File: logic/issue_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl (
	input  backend_pkg::inst_word_t [backend_pkg::ISSUE_WIDTH-1:0] inst_i,
	input  logic [backend_pkg::ISSUE_WIDTH-1:0] inst_valid_i,
	input  logic                   freeze_i,
	input  logic                   p0_ex_load_i,
	input  backend_pkg::reg_addr_t p0_ex_rd_i, // zero when invalid or not writing
	input  backend_pkg::reg_addr_t p1_ex_rd_i,
	input  backend_pkg::reg_addr_t p0_m1_rd_i,
	input  backend_pkg::reg_addr_t p1_m1_rd_i,
	input  logic                   ex_revert_i, // pipe 0 holds the younger of the ex pair
	input  logic                   m1_revert_i,

	output logic [backend_pkg::ISSUE_WIDTH-1:0] issue_o, // per pipe
	output logic                                revert_o,
	output backend_pkg::reg_addr_t [2*backend_pkg::ISSUE_WIDTH-1:0] rs_addr_o, // pipe order
	output backend_pkg::fwd_src_t  [2*backend_pkg::ISSUE_WIDTH-1:0] fwd_src_o
);
	import backend_pkg::*;

	op_t       [ISSUE_WIDTH-1:0] op;
	reg_addr_t [ISSUE_WIDTH-1:0] rd, src1, src2; // zeroed when unused
	logic      [ISSUE_WIDTH-1:0] mem_op;
	logic      [ISSUE_WIDTH-1:0] load_hit; // waits on the load in p0 ex
	logic                        pair_dep;

	// youngest matching producer wins and ex beats m1
	function automatic fwd_src_t fwd_pick(input reg_addr_t r,
		input reg_addr_t ex0, input reg_addr_t ex1, input reg_addr_t m10,
		input reg_addr_t m11, input logic ex_rev, input logic m1_rev);
		fwd_src_t sel;
		sel = FWD_NONE;
		if (r != '0) begin
			if (ex0 == r && ex1 == r)
				sel = ex_rev ? FWD_P0_M1 : FWD_P1_M1;
			else if (ex0 == r)
				sel = FWD_P0_M1;
			else if (ex1 == r)
				sel = FWD_P1_M1;
			else if (m10 == r && m11 == r)
				sel = m1_rev ? FWD_P0_M2 : FWD_P1_M2;
			else if (m10 == r)
				sel = FWD_P0_M2;
			else if (m11 == r)
				sel = FWD_P1_M2;
		end
		return sel;
	endfunction

	always_comb begin
		for (int s = 0; s < ISSUE_WIDTH; s++) begin
			op[s]     = inst_op(inst_i[s]);
			rd[s]     = writes_rd(op[s]) ? inst_rd(inst_i[s]) : '0;
			src1[s]   = uses_rs1(op[s]) ? inst_rs1(inst_i[s]) : '0;
			src2[s]   = uses_rs2(op[s]) ? inst_rs2(inst_i[s]) : '0;
			mem_op[s] = is_mem(op[s]);
			// load data not ready for an ex right behind it
			load_hit[s] = p0_ex_load_i && p0_ex_rd_i != '0 &&
				(src1[s] == p0_ex_rd_i || src2[s] == p0_ex_rd_i);
		end
		pair_dep = rd[0] != '0 && (src1[1] == rd[0] || src2[1] == rd[0]); // raw inside pair
	end

	always_comb begin
		issue_o  = '0;
		revert_o = 1'b0;
		if (!freeze_i && inst_valid_i[0] && !load_hit[0]) begin
			issue_o[0] = 1'b1;
			if (inst_valid_i[1] && !load_hit[1] && !pair_dep && !(mem_op[0] && mem_op[1])) begin
				issue_o[1] = 1'b1;
				revert_o   = mem_op[1] && !mem_op[0]; // mem op must land in pipe 0
			end
		end
	end

	// operands in pipe order where pipe p holds slot p ^ revert
	always_comb begin
		for (int p = 0; p < ISSUE_WIDTH; p++) begin
			rs_addr_o[2*p]   = src1[p ^ int'(revert_o)];
			rs_addr_o[2*p+1] = src2[p ^ int'(revert_o)];
			for (int k = 0; k < 2; k++) begin
				fwd_src_o[2*p+k] = fwd_pick(rs_addr_o[2*p+k], p0_ex_rd_i, p1_ex_rd_i,
					p0_m1_rd_i, p1_m1_rd_i, ex_revert_i, m1_revert_i);
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic clk,
	input  logic rst_n_i,

	input  backend_pkg::reg_addr_t [backend_pkg::ISSUE_WIDTH-1:0] w_addr_i, // port 1 younger
	input  backend_pkg::word_t     [backend_pkg::ISSUE_WIDTH-1:0] w_data_i,
	input  logic                   [backend_pkg::ISSUE_WIDTH-1:0] w_en_i,

	input  backend_pkg::reg_addr_t [2*backend_pkg::ISSUE_WIDTH-1:0] r_addr_i,
	output backend_pkg::word_t     [2*backend_pkg::ISSUE_WIDTH-1:0] r_data_o
);
	import backend_pkg::*;

	word_t regs [NUM_REGS];

	// later port overrides on same address
	always_ff @(posedge clk) begin
		for (int w = 0; w < ISSUE_WIDTH; w++) begin
			if (w_en_i[w])
				regs[w_addr_i[w]] <= w_data_i[w];
		end
	end

	always_comb begin
		for (int i = 0; i < 2*ISSUE_WIDTH; i++) begin
			if (r_addr_i[i] == '0)
				r_data_o[i] = '0; // r0 hard zero
			else if (w_en_i[1] && w_addr_i[1] == r_addr_i[i])
				r_data_o[i] = w_data_i[1]; // bypass, younger first
			else if (w_en_i[0] && w_addr_i[0] == r_addr_i[i])
				r_data_o[i] = w_data_i[0];
			else
				r_data_o[i] = regs[r_addr_i[i]];
		end
	end

	// write-back is expected to filter r0 upstream
	a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
		!(w_en_i[0] && w_addr_i[0] == '0) && !(w_en_i[1] && w_addr_i[1] == '0))
		else $error("reg_file: write to r0");

endmodule

`default_nettype wire

// File: src.f
logic/backend_pkg.sv
logic/issue_ctrl.sv
logic/reg_file.sv
logic/backend_pipeline.sv
logic/backend.sv
verification/data_mem_model.sv
verification/backend_tb.sv

// File: verification/backend_tb.sv
`timescale 1ns/1ps
`default_nettype none

module backend_tb;
	import backend_pkg::*;

	localparam int CLK_PERIOD = 8;

	logic            clk;
	logic            rst_n;
	inst_word_t [1:0] inst;
	logic [1:0]      inst_valid;
	logic [1:0]      issue_num;
	logic            stall;
	logic            bus_req, bus_we, bus_ack;
	word_t           bus_addr, bus_wdata, bus_rdata;
	logic [1:0]      commit_we;
	reg_addr_t [1:0] commit_addr;
	word_t [1:0]     commit_data;

	inst_word_t prog[$];      // program being built by a test
	inst_word_t fe_q[$];      // frontend queue, head at index 0
	word_t      gold_reg [32];
	word_t      gold_mem [256];
	int         exp_rd[$];    // expected commits, program order
	word_t      exp_val[$];
	word_t      exp_bus_addr[$];
	logic       exp_bus_we[$];
	word_t      exp_bus_wdata[$];
	op_t        alu_set [6] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI};

	int         errors = 0;
	int         commits_seen = 0;
	int         bus_seen = 0;
	int         cycle_cnt = 0;
	int         cycle_budget = 200; // grows by 40 per instruction
	bit         expect_dual = 1'b0;
	logic [1:0] issued;

	backend UUT (
		.clk             (clk),
		.rst_n_i         (rst_n),
		.inst_i          (inst),
		.inst_valid_i    (inst_valid),
		.issue_num_o     (issue_num),
		.backend_stall_o (stall),
		.bus_req_o       (bus_req),
		.bus_we_o        (bus_we),
		.bus_addr_o      (bus_addr),
		.bus_wdata_o     (bus_wdata),
		.bus_ack_i       (bus_ack),
		.bus_rdata_i     (bus_rdata),
		.commit_we_o     (commit_we),
		.commit_addr_o   (commit_addr),
		.commit_data_o   (commit_data)
	);

	data_mem_model mem_model (
		.clk         (clk),
		.rst_n_i     (rst_n),
		.bus_req_i   (bus_req),
		.bus_we_i    (bus_we),
		.bus_addr_i  (bus_addr),
		.bus_wdata_i (bus_wdata),
		.bus_ack_o   (bus_ack),
		.bus_rdata_o (bus_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	initial begin
		wait (cycle_cnt > cycle_budget);
		$display("watchdog: no finish after %0d cycles", cycle_budget);
		$display("TEST FAILED");
		$finish;
	end

	// fields: op 31:28, rd 27:23, rs1 22:18, rs2 17:13, imm 12:0
	function automatic inst_word_t enc(op_t op, int rd, int rs1, int rs2, int imm);
		return {op, 5'(rd), 5'(rs1), 5'(rs2), 13'(imm)};
	endfunction

	function automatic word_t sext(inst_word_t w);
		return {{19{w[12]}}, w[12:0]};
	endfunction

	function automatic int dest_of(inst_word_t w);
		if (w[31:28] inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LW})
			return int'(w[27:23]);
		return 0;
	endfunction

	function automatic bit reads_reg(inst_word_t w, int r);
		bit r1, r2;
		r1 = w[31:28] inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LW, OP_SW};
		r2 = w[31:28] inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SW};
		return r != 0 && ((r1 && int'(w[22:18]) == r) || (r2 && int'(w[17:13]) == r));
	endfunction

	function automatic bit mem_access(inst_word_t w);
		return w[31:28] == OP_LW || w[31:28] == OP_SW;
	endfunction

	task automatic report_mismatch(string sig, word_t exp, word_t act);
		errors++;
		$display("[ERROR] t=%0t %s expected %h actual %h", $time, sig, exp, act);
	endtask

	task automatic report_failure(string what);
		errors++;
		$display("error at %0t: %s", $time, what);
	endtask

	// sequential reference, one instruction at a time
	task automatic gold_exec(inst_word_t w);
		word_t a, b, res, addr;
		bit    wr;
		a    = gold_reg[w[22:18]];
		b    = gold_reg[w[17:13]];
		addr = a + sext(w);
		res  = '0;
		wr   = 1'b1;
		case (w[31:28])
			OP_ADD:  res = a + b;
			OP_SUB:  res = a - b;
			OP_AND:  res = a & b;
			OP_OR:   res = a | b;
			OP_XOR:  res = a ^ b;
			OP_ADDI: res = addr;
			OP_LW: begin
				res = gold_mem[addr[7:0]];
				exp_bus_addr.push_back(addr);
				exp_bus_we.push_back(1'b0);
				exp_bus_wdata.push_back('0);
			end
			OP_SW: begin
				wr = 1'b0;
				gold_mem[addr[7:0]] = b;
				exp_bus_addr.push_back(addr);
				exp_bus_we.push_back(1'b1);
				exp_bus_wdata.push_back(b);
			end
			default: wr = 1'b0; // nop and unused codes
		endcase
		if (wr && w[27:23] != 5'd0) begin
			gold_reg[w[27:23]] = res;
			exp_rd.push_back(int'(w[27:23]));
			exp_val.push_back(res);
		end
	endtask

	task automatic drive_slots();
		inst       = '0;
		inst_valid = '0;
		if (fe_q.size() > 0) begin
			inst[0]       = fe_q[0];
			inst_valid[0] = 1'b1;
		end
		if (fe_q.size() > 1) begin
			inst[1]       = fe_q[1];
			inst_valid[1] = 1'b1;
		end
	endtask

	task automatic check_commit(int i);
		commits_seen++;
		if (commit_addr[i] == 5'd0)
			report_failure("a write to r0 showed up on the commit trace");
		else if (exp_rd.size() == 0)
			report_failure("commit seen with nothing left to retire");
		else begin
			if (int'(commit_addr[i]) != exp_rd[0])
				report_mismatch($sformatf("commit_addr_o[%0d]", i), word_t'(exp_rd[0]),
					word_t'(commit_addr[i]));
			if (commit_data[i] !== exp_val[0])
				report_mismatch($sformatf("commit_data_o[%0d]", i), exp_val[0], commit_data[i]);
			void'(exp_rd.pop_front());
			void'(exp_val.pop_front());
		end
	endtask

	// sampled at the falling edge, outputs settled
	task automatic check_cycle();
		int presented;
		presented = int'(inst_valid[0]) + int'(inst_valid[1]);
		issued    = issue_num;
		if (int'(issue_num) > presented)
			report_mismatch("issue_num_o", word_t'(presented), word_t'(issue_num));
		if (stall && issue_num !== 2'd0)
			report_mismatch("issue_num_o", 0, word_t'(issue_num));
		if (inst_valid == 2'b11) begin
			if (expect_dual && issue_num !== 2'd2)
				report_mismatch("issue_num_o", 2, word_t'(issue_num));
			if (issue_num == 2'd2 && reads_reg(inst[1], dest_of(inst[0])))
				report_failure("pair issued although slot 1 reads the rd of slot 0");
			if (issue_num == 2'd2 && mem_access(inst[0]) && mem_access(inst[1]))
				report_failure("two memory operations issued in one cycle");
		end
		if (commit_we[0])
			check_commit(0); // older first
		if (commit_we[1])
			check_commit(1);
		if (bus_req && bus_ack) begin
			bus_seen++;
			if (exp_bus_addr.size() == 0)
				report_failure("memory request that the program does not make");
			else begin
				if (bus_addr !== exp_bus_addr[0])
					report_mismatch("bus_addr_o", exp_bus_addr[0], bus_addr);
				if (bus_we !== exp_bus_we[0])
					report_mismatch("bus_we_o", word_t'(exp_bus_we[0]), word_t'(bus_we));
				if (exp_bus_we[0] && bus_wdata !== exp_bus_wdata[0])
					report_mismatch("bus_wdata_o", exp_bus_wdata[0], bus_wdata);
				void'(exp_bus_addr.pop_front());
				void'(exp_bus_we.pop_front());
				void'(exp_bus_wdata.pop_front());
			end
		end
	endtask

	// one cycle, frontend pops what was issued
	task automatic step();
		@(negedge clk);
		check_cycle();
		@(posedge clk);
		for (int k = 0; k < int'(issued) && fe_q.size() > 0; k++)
			void'(fe_q.pop_front());
		#1;
		drive_slots();
	endtask

	task automatic run_prog();
		int wait_left;
		cycle_budget += 40 * prog.size();
		foreach (prog[k]) begin
			gold_exec(prog[k]);
			fe_q.push_back(prog[k]);
		end
		prog.delete();
		drive_slots();
		while (fe_q.size() > 0)
			step();
		wait_left = 40; // memory waits can stretch the tail
		while ((exp_rd.size() > 0 || exp_bus_addr.size() > 0) && wait_left > 0) begin
			step();
			wait_left--;
		end
		repeat (6) step();
		if (exp_rd.size() != 0)
			report_failure($sformatf("%0d expected commits never appeared", exp_rd.size()));
		if (exp_bus_addr.size() != 0)
			report_failure($sformatf("%0d memory accesses never made", exp_bus_addr.size()));
		for (int i = 0; i < 256; i++) begin
			if (mem_model.mem[i] !== gold_mem[i])
				report_mismatch($sformatf("mem[%0d]", i), gold_mem[i], mem_model.mem[i]);
		end
	endtask

	task automatic check_reset_state();
		@(negedge clk);
		if (issue_num !== 2'd0)
			report_mismatch("issue_num_o", 0, word_t'(issue_num));
		if (bus_req !== 1'b0)
			report_mismatch("bus_req_o", 0, word_t'(bus_req));
		if (commit_we !== 2'b00)
			report_mismatch("commit_we_o", 0, word_t'(commit_we));
		if (stall !== 1'b0)
			report_mismatch("backend_stall_o", 0, word_t'(stall));
		@(posedge clk);
		#1;
	endtask

	task automatic test_load_regs();
		for (int r = 1; r < 32; r++)
			prog.push_back(enc(OP_ADDI, r, 0, 0, r * 97 - 1500)); // some negative imm
		run_prog();
	endtask

	task automatic test_alu_pairs();
		int rd0, s1, s2;
		for (int k = 0; k < 24; k++) begin
			rd0 = 1 + int'($urandom % 31);
			prog.push_back(enc(alu_set[k % 6], rd0, int'($urandom % 32), int'($urandom % 32),
				int'($urandom % 8192) - 4096));
			s1 = int'($urandom % 32);
			s2 = int'($urandom % 32);
			if (s1 == rd0)
				s1 = 0; // keep the pair independent
			if (s2 == rd0)
				s2 = 0;
			prog.push_back(enc(alu_set[(k + 3) % 6], 1 + int'($urandom % 31), s1, s2,
				int'($urandom % 8192) - 4096));
		end
		expect_dual = 1'b1;
		run_prog();
		expect_dual = 1'b0;
	endtask

	task automatic test_dep_chains();
		prog.push_back(enc(OP_ADDI, 1, 1, 0, 3));
		prog.push_back(enc(OP_ADD, 2, 1, 1, 0));  // slot 1 reads slot 0
		prog.push_back(enc(OP_SUB, 3, 2, 1, 0));
		prog.push_back(enc(OP_XOR, 3, 4, 5, 0));  // same rd pair
		prog.push_back(enc(OP_ADD, 6, 3, 3, 0));  // needs the younger r3
		prog.push_back(enc(OP_OR, 7, 6, 2, 0));
		// few registers, so deps land at every distance
		for (int k = 0; k < 40; k++)
			prog.push_back(enc(alu_set[$urandom % 6], 1 + int'($urandom % 6),
				int'($urandom % 7), int'($urandom % 7), int'($urandom % 64) - 32));
		run_prog();
	endtask

	task automatic test_mem();
		prog.push_back(enc(OP_ADDI, 20, 0, 0, 16));  // base registers
		prog.push_back(enc(OP_ADDI, 21, 0, 0, 100));
		prog.push_back(enc(OP_LW, 1, 20, 0, 4));
		prog.push_back(enc(OP_ADD, 2, 1, 1, 0));     // load use
		prog.push_back(enc(OP_SW, 0, 21, 2, 3));
		prog.push_back(enc(OP_LW, 3, 21, 0, 3));     // reads the store back
		prog.push_back(enc(OP_XOR, 4, 3, 1, 0));
		prog.push_back(enc(OP_ADDI, 5, 4, 0, -7));
		prog.push_back(enc(OP_SW, 0, 20, 5, -2));
		for (int k = 0; k < 40; k++) begin
			case ($urandom % 4)
				0: prog.push_back(enc(OP_LW, 1 + int'($urandom % 8), 20 + int'($urandom % 2),
					0, int'($urandom % 32)));
				1: prog.push_back(enc(OP_SW, 0, 20 + int'($urandom % 2), int'($urandom % 9),
					int'($urandom % 32)));
				2: prog.push_back(enc(alu_set[$urandom % 5], 1 + int'($urandom % 8),
					int'($urandom % 9), int'($urandom % 9), 0));
				default: prog.push_back(enc(OP_ADDI, 1 + int'($urandom % 8),
					int'($urandom % 9), 0, int'($urandom % 16) - 8));
			endcase
		end
		run_prog();
	endtask

	task automatic test_r0();
		prog.push_back(enc(OP_ADDI, 0, 0, 0, 55));   // dropped write
		prog.push_back(enc(OP_ADD, 1, 0, 0, 0));
		prog.push_back(enc(OP_ADDI, 0, 3, 0, 7));
		prog.push_back(enc(OP_ADD, 2, 0, 4, 0));     // r0 right behind a write to it
		prog.push_back(enc(OP_LW, 0, 20, 0, 1));
		prog.push_back(enc(OP_SUB, 3, 5, 0, 0));
		prog.push_back(enc(OP_SW, 0, 20, 0, 2));     // stores zero
		prog.push_back(enc(OP_XOR, 0, 1, 2, 0));
		prog.push_back(enc(OP_OR, 4, 0, 3, 0));
		run_prog();
	endtask

	initial begin
		void'($urandom(32'h8845ec0f));
		rst_n      = 1'b0;
		inst       = '0;
		inst_valid = '0;
		foreach (gold_reg[r])
			gold_reg[r] = '0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		foreach (gold_mem[i])
			gold_mem[i] = mem_model.mem[i]; // preset contents of the memory
		check_reset_state();
		test_load_regs();
		test_alu_pairs();
		test_dep_chains();
		test_mem();
		test_r0();
		$display("errors %0d, commits checked %0d, memory accesses checked %0d",
			errors, commits_seen, bus_seen);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/data_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem_model (
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic        bus_req_i,   // level, held until ack
	input  logic        bus_we_i,
	input  logic [31:0] bus_addr_i,  // word address, low 8 bits used
	input  logic [31:0] bus_wdata_i,
	output logic        bus_ack_o,   // one cycle pulse
	output logic [31:0] bus_rdata_o
);
	logic [31:0] mem [256];
	logic [1:0]  wait_cnt; // cycles the current request has waited
	logic [1:0]  delay;    // wait drawn for the next request

	// preset pattern, every address bit shows up in its word
	initial begin
		for (int i = 0; i < 256; i++)
			mem[i] = {8'(i), ~8'(i), 8'(i * 3), 8'(i ^ 8'h5a)};
	end

	assign bus_ack_o   = bus_req_i && wait_cnt == delay;
	assign bus_rdata_o = mem[bus_addr_i[7:0]]; // valid with the ack

	always @(posedge clk) begin
		if (!rst_n_i) begin
			wait_cnt <= '0;
			delay    <= '0;
		end else if (bus_ack_o) begin
			wait_cnt <= '0;
			delay    <= 2'($urandom % 4); // 0 to 3 cycles
			if (bus_we_i)
				mem[bus_addr_i[7:0]] <= bus_wdata_i;
		end else if (bus_req_i) begin
			wait_cnt <= wait_cnt + 2'd1;
		end
	end

endmodule

`default_nettype wire
